/* source/mipsPkg.sv */
`default_nettype none

package mipsPkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0] regAddr_t;

  // Major opcodes, MIPS32 encodings
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_BGTZ  = 6'b000111,
    OP_ADDIU = 6'b001001,
    OP_SLTI  = 6'b001010,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_LB    = 6'b100000,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcode_t;

  // Function field of R-type instructions
  typedef enum logic [5:0] {
    FN_JR   = 6'b001000,
    FN_JALR = 6'b001001,
    FN_ADDU = 6'b100001,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101
  } funct_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_PASSA,
    ALU_GTZ
  } aluOp_t;

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXEC1,
    ST_EXEC2,
    ST_EXEC3,
    ST_HALTED
  } cpuState_t;

  typedef enum logic [1:0] {
    SRCB_REG,
    SRCB_FOUR,
    SRCB_SIMM,
    SRCB_ZIMM
  } aluSrcB_t;

  // Register file write value
  typedef enum logic [1:0] {
    RES_ALU,
    RES_WORD,
    RES_BYTE,
    RES_PC
  } resultSel_t;

  typedef struct packed {
    logic       irWrite;
    logic       pcWrite;
    logic       pcFromAluOut;
    logic       pcFromJump;
    logic       iorD;
    logic       aluSrcA;     // 0 selects PC, 1 selects A
    aluSrcB_t   aluSrcB;
    aluOp_t     aluOp;
    logic       regWrite;
    logic       regDstRd;
    logic       regDstRa;
    resultSel_t resultSel;
    logic       memRead;
    logic       memWrite;
  } ctrl_t;

  typedef struct packed {
    opcode_t opcode;
    funct_t  funct;
    logic    aluZero;        // Next PC value is zero
    logic    aluGtz;
  } instrInfo_t;

endpackage

`default_nettype wire

/* source/aluUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
  input  mipsPkg::word_t  a,
  input  mipsPkg::word_t  b,
  input  mipsPkg::aluOp_t op,
  output mipsPkg::word_t  y,
  output logic            zero,
  output logic            gtz
);
  import mipsPkg::*;

  logic lessThan;

  assign lessThan = $signed(a) < $signed(b);

  // Positive and nonzero
  assign gtz = !a[31] && (a != '0);

  always_comb begin
    case (op)
      ALU_ADD: y = a + b;
      ALU_AND: y = a & b;
      ALU_OR: y = a | b;
      ALU_SLT: y = {{31{1'b0}}, lessThan};
      ALU_PASSA: y = a;
      ALU_GTZ: y = {{31{1'b0}}, gtz};
      default: y = '0;
    endcase
  end

  assign zero = (y == '0);

endmodule

`default_nettype wire

/* source/registerFile.sv */
`timescale 1ns/100ps
`default_nettype none

module registerFile (
  input  logic              clk,
  input  logic              arstN,
  input  mipsPkg::regAddr_t raddr1,
  input  mipsPkg::regAddr_t raddr2,
  output mipsPkg::word_t    rdata1,
  output mipsPkg::word_t    rdata2,
  input  logic              we,
  input  mipsPkg::regAddr_t waddr,
  input  mipsPkg::word_t    wdata
);
  import mipsPkg::*;

  word_t regs [32];

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

  // Register 0 is never written so it reads as zero
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

`default_nettype wire

/* source/controlFsm.sv */
`timescale 1ns/100ps
`default_nettype none

module controlFsm (
  input  logic                clk,
  input  logic                arstN,
  input  logic                stall,
  input  mipsPkg::instrInfo_t info,
  output mipsPkg::ctrl_t      ctrl,
  output logic                halted
);
  import mipsPkg::*;

  cpuState_t state;
  cpuState_t stateNext;
  ctrl_t     c;
  logic      lastStep;
  logic      memWait;

  function automatic logic supported(opcode_t op, funct_t fn);
    logic ok;
    case (op)
      OP_RTYPE: ok = fn inside {FN_ADDU, FN_AND, FN_OR, FN_JR, FN_JALR};
      OP_J, OP_BGTZ, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI,
      OP_LB, OP_LW, OP_SW: ok = 1'b1;
      default: ok = 1'b0;
    endcase
    return ok;
  endfunction

  // Raw control levels for the current state and instruction
  always_comb begin
    c = '0;
    lastStep = 1'b0;
    case (state)
      ST_FETCH: begin
        c.memRead = 1'b1;
        c.irWrite = 1'b1;
        c.pcWrite = 1'b1;
        c.aluSrcB = SRCB_FOUR;
        c.aluOp = ALU_ADD;
      end
      // Branch target goes into ALU out
      ST_DECODE: begin
        c.aluSrcB = SRCB_SIMM;
        c.aluOp = ALU_ADD;
      end
      ST_EXEC1, ST_EXEC2, ST_EXEC3: begin
        c.aluSrcA = 1'b1;
        case (info.opcode)
          OP_RTYPE: begin
            case (info.funct)
              FN_JR: begin
                c.aluOp = ALU_PASSA;
                c.pcWrite = 1'b1;
                lastStep = 1'b1;
              end
              FN_JALR: begin
                c.aluOp = ALU_PASSA;
                if (state == ST_EXEC1) begin
                  // Link first, target waits in ALU out
                  c.regWrite = 1'b1;
                  c.regDstRa = 1'b1;
                  c.resultSel = RES_PC;
                end else begin
                  c.pcWrite = 1'b1;
                  c.pcFromAluOut = 1'b1;
                  lastStep = 1'b1;
                end
              end
              default: begin
                c.aluSrcB = SRCB_REG;
                case (info.funct)
                  FN_AND: c.aluOp = ALU_AND;
                  FN_OR: c.aluOp = ALU_OR;
                  default: c.aluOp = ALU_ADD;
                endcase
                if (state == ST_EXEC2) begin
                  c.regWrite = 1'b1;
                  c.regDstRd = 1'b1;
                  c.resultSel = RES_ALU;
                  lastStep = 1'b1;
                end
              end
            endcase
          end
          OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI: begin
            case (info.opcode)
              OP_ANDI: c.aluOp = ALU_AND;
              OP_ORI: c.aluOp = ALU_OR;
              OP_SLTI: c.aluOp = ALU_SLT;
              default: c.aluOp = ALU_ADD;
            endcase
            // Logical immediates are zero extended
            if (info.opcode inside {OP_ANDI, OP_ORI}) begin
              c.aluSrcB = SRCB_ZIMM;
            end else begin
              c.aluSrcB = SRCB_SIMM;
            end
            if (state == ST_EXEC2) begin
              c.regWrite = 1'b1;
              c.resultSel = RES_ALU;
              lastStep = 1'b1;
            end
          end
          OP_LW, OP_LB, OP_SW: begin
            // Address stays in ALU out for every step
            c.aluSrcB = SRCB_SIMM;
            c.aluOp = ALU_ADD;
            if (state == ST_EXEC2) begin
              c.iorD = 1'b1;
              c.memRead = (info.opcode != OP_SW);
              c.memWrite = (info.opcode == OP_SW);
              lastStep = (info.opcode == OP_SW);
            end else if (state == ST_EXEC3) begin
              c.regWrite = 1'b1;
              c.resultSel = (info.opcode == OP_LW) ? RES_WORD : RES_BYTE;
              lastStep = 1'b1;
            end
          end
          OP_J: begin
            c.pcWrite = 1'b1;
            c.pcFromJump = 1'b1;
            lastStep = 1'b1;
          end
          OP_BGTZ: begin
            c.aluOp = ALU_GTZ;
            c.pcWrite = info.aluGtz;
            c.pcFromAluOut = 1'b1;
            lastStep = 1'b1;
          end
          default: lastStep = 1'b1;
        endcase
      end
      default: c = '0;
    endcase
  end

  assign memWait = stall && (c.memRead || c.memWrite);

  // A stalled access keeps its strobe and address but commits nothing
  always_comb begin
    ctrl = c;
    if (memWait) begin
      ctrl.irWrite = 1'b0;
      ctrl.pcWrite = 1'b0;
      ctrl.regWrite = 1'b0;
    end
  end

  always_comb begin
    stateNext = state;
    if (!memWait) begin
      case (state)
        ST_FETCH: stateNext = ST_DECODE;
        ST_DECODE: stateNext = supported(info.opcode, info.funct) ? ST_EXEC1 : ST_HALTED;
        ST_EXEC1, ST_EXEC2, ST_EXEC3: begin
          if (ctrl.pcWrite && info.aluZero) begin
            stateNext = ST_HALTED;
          end else if (lastStep) begin
            stateNext = ST_FETCH;
          end else if (state == ST_EXEC1) begin
            stateNext = ST_EXEC2;
          end else begin
            stateNext = ST_EXEC3;
          end
        end
        default: stateNext = ST_HALTED;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= ST_FETCH;
    end else begin
      state <= stateNext;
    end
  end

  assign halted = (state == ST_HALTED);

endmodule

`default_nettype wire

/* source/dataPath.sv */
`timescale 1ns/100ps
`default_nettype none

module dataPath #(
  parameter mipsPkg::word_t RESET_PC = '0
) (
  input  logic                clk,
  input  logic                arstN,
  input  mipsPkg::ctrl_t      ctrl,
  input  mipsPkg::word_t      memRdata,
  output mipsPkg::instrInfo_t info,
  output mipsPkg::word_t      memAddr,
  output mipsPkg::word_t      memWdata
);
  import mipsPkg::*;

  word_t    pc;
  word_t    ir;
  word_t    mdr;
  word_t    regA;
  word_t    regB;
  word_t    aluOut;
  word_t    rdata1;
  word_t    rdata2;
  word_t    srcA;
  word_t    srcB;
  word_t    aluY;
  word_t    immS;
  word_t    immZ;
  word_t    jumpTarget;
  word_t    pcNext;
  word_t    byteExt;
  word_t    wdata;
  regAddr_t waddr;
  logic     aluZero;
  logic     aluGtz;
  logic     [7:0] memByte;

  assign immS = {{16{ir[15]}}, ir[15:0]};
  assign immZ = {16'h0000, ir[15:0]};
  assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

  assign srcA = ctrl.aluSrcA ? regA : pc;

  // With PC as operand the immediate is a word offset
  always_comb begin
    case (ctrl.aluSrcB)
      SRCB_REG: srcB = regB;
      SRCB_FOUR: srcB = 32'd4;
      SRCB_SIMM: srcB = ctrl.aluSrcA ? immS : {immS[29:0], 2'b00};
      default: srcB = immZ;
    endcase
  end

  aluUnit i_aluUnit (
    .a(srcA),
    .b(srcB),
    .op(ctrl.aluOp),
    .y(aluY),
    .zero(aluZero),
    .gtz(aluGtz)
  );

  assign pcNext = ctrl.pcFromJump ? jumpTarget : (ctrl.pcFromAluOut ? aluOut : aluY);

  assign info.opcode = opcode_t'(ir[31:26]);
  assign info.funct = funct_t'(ir[5:0]);
  assign info.aluGtz = aluGtz;
  always_comb begin
    if (ctrl.pcFromJump) begin
      info.aluZero = (jumpTarget == '0);
    end else if (ctrl.pcFromAluOut) begin
      info.aluZero = (aluOut == '0);
    end else begin
      info.aluZero = aluZero;
    end
  end

  assign memAddr = ctrl.iorD ? aluOut : pc;
  assign memWdata = regB;

  // Little endian byte lane for LB
  always_comb begin
    case (aluOut[1:0])
      2'd0: memByte = mdr[7:0];
      2'd1: memByte = mdr[15:8];
      2'd2: memByte = mdr[23:16];
      default: memByte = mdr[31:24];
    endcase
  end
  assign byteExt = {{24{memByte[7]}}, memByte};

  always_comb begin
    case (ctrl.resultSel)
      RES_ALU: wdata = aluOut;
      RES_WORD: wdata = mdr;
      RES_BYTE: wdata = byteExt;
      default: wdata = pc;
    endcase
  end

  assign waddr = ctrl.regDstRa ? 5'd31 : (ctrl.regDstRd ? ir[15:11] : ir[20:16]);

  registerFile i_registerFile (
    .clk(clk),
    .arstN(arstN),
    .raddr1(ir[25:21]),
    .raddr2(ir[20:16]),
    .rdata1(rdata1),
    .rdata2(rdata2),
    .we(ctrl.regWrite),
    .waddr(waddr),
    .wdata(wdata)
  );

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= RESET_PC;
    end else if (ctrl.pcWrite) begin
      pc <= pcNext;
    end
  end

  // Holding registers between steps
  always_ff @(posedge clk) begin
    if (ctrl.irWrite) begin
      ir <= memRdata;
    end
    mdr <= memRdata;
    regA <= rdata1;
    regB <= rdata2;
    aluOut <= aluY;
  end

endmodule

`default_nettype wire

/* source/mipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore #(
  parameter mipsPkg::word_t RESET_PC = '0
) (
  input  logic           clk,
  input  logic           arstN,
  input  mipsPkg::word_t memRdata,
  input  logic           stall,
  output mipsPkg::word_t memAddr,
  output mipsPkg::word_t memWdata,
  output logic           memRead,
  output logic           memWrite,
  output logic           halted
);
  import mipsPkg::*;

  ctrl_t      ctrl;
  instrInfo_t info;

  controlFsm i_controlFsm (
    .clk(clk),
    .arstN(arstN),
    .stall(stall),
    .info(info),
    .ctrl(ctrl),
    .halted(halted)
  );

  dataPath #(
    .RESET_PC(RESET_PC)
  ) i_dataPath (
    .clk(clk),
    .arstN(arstN),
    .ctrl(ctrl),
    .memRdata(memRdata),
    .info(info),
    .memAddr(memAddr),
    .memWdata(memWdata)
  );

  // Strobes come straight from the control levels
  assign memRead = ctrl.memRead;
  assign memWrite = ctrl.memWrite;

endmodule

`default_nettype wire

/* sim/mipsCore_props.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCoreProps (
  input logic                clk,
  input logic                arstN,
  input logic                stall,
  input mipsPkg::cpuState_t  state,
  input mipsPkg::ctrl_t      ctrl
);
  import mipsPkg::*;

  int failCount = 0;

  // One direction per cycle on the shared port
  assert property (@(posedge clk) disable iff (!arstN)
    !(ctrl.memRead && ctrl.memWrite))
    else begin
      failCount++;
      $error("memRead and memWrite high together");
    end

  assert property (@(posedge clk) disable iff (!arstN)
    (state == ST_HALTED) |-> (!ctrl.memRead && !ctrl.memWrite && !ctrl.regWrite))
    else begin
      failCount++;
      $error("Strobe active while halted");
    end

  // A stalled access keeps its strobe and address select
  assert property (@(posedge clk) disable iff (!arstN)
    (stall && (ctrl.memRead || ctrl.memWrite)) |=>
      ($stable(ctrl.memRead) && $stable(ctrl.memWrite) && $stable(ctrl.iorD)))
    else begin
      failCount++;
      $error("Memory access changed under stall");
    end

endmodule

bind controlFsm mipsCoreProps i_mipsCoreProps (
  .clk(clk),
  .arstN(arstN),
  .stall(stall),
  .state(state),
  .ctrl(ctrl)
);

`default_nettype wire

/* sim/mipsCore_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore_tb;
  import mipsPkg::*;

  localparam word_t RESET_PC = 32'h100;
  localparam int RESET_CYCLES = 8;
  localparam int MEM_WORDS = 1024;

  // MIPS32 encodings used to assemble the program
  localparam logic [5:0] OPC_SPECIAL = 6'h00;
  localparam logic [5:0] OPC_J = 6'h02;
  localparam logic [5:0] OPC_BGTZ = 6'h07;
  localparam logic [5:0] OPC_ADDIU = 6'h09;
  localparam logic [5:0] OPC_SLTI = 6'h0a;
  localparam logic [5:0] OPC_ANDI = 6'h0c;
  localparam logic [5:0] OPC_ORI = 6'h0d;
  localparam logic [5:0] OPC_LB = 6'h20;
  localparam logic [5:0] OPC_LW = 6'h23;
  localparam logic [5:0] OPC_SW = 6'h2b;
  localparam logic [5:0] FUN_JR = 6'h08;
  localparam logic [5:0] FUN_JALR = 6'h09;
  localparam logic [5:0] FUN_ADDU = 6'h21;
  localparam logic [5:0] FUN_AND = 6'h24;
  localparam logic [5:0] FUN_OR = 6'h25;

  logic  clk = 1'b0;
  logic  arstN;
  logic  stall;
  word_t memRdata;
  word_t memAddr;
  word_t memWdata;
  logic  memRead;
  logic  memWrite;
  logic  halted;

  word_t mem [MEM_WORDS];
  word_t refMem [MEM_WORDS];
  word_t expAddr [$];
  word_t expData [$];
  word_t gotAddr [$];
  word_t gotData [$];
  word_t lfsr;
  logic  stallBit;
  logic  stalledAccess;
  word_t stalledAddr;
  int    errors;
  int    checks;
  int    storeCount;
  int    instrCount;
  int    cycleLimit;
  int    cycles;
  int    assertFails;

  mipsCore #(
    .RESET_PC(RESET_PC)
  ) i_mipsCore (
    .clk(clk),
    .arstN(arstN),
    .memRdata(memRdata),
    .stall(stall),
    .memAddr(memAddr),
    .memWdata(memWdata),
    .memRead(memRead),
    .memWrite(memWrite),
    .halted(halted)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic word_t nextLfsr(word_t s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic word_t encodeR(int rs, int rt, int rd, logic [5:0] fn);
    return {OPC_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic word_t encodeI(logic [5:0] op, int rs, int rt, int imm);
    return {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic word_t encodeJ(int k);
    word_t target;
    target = RESET_PC + word_t'(k * 4);
    return {OPC_J, target[27:2]};
  endfunction

  task automatic placeInstr(int k, word_t w);
    word_t addr;
    addr = RESET_PC + word_t'(k * 4);
    mem[addr[11:2]] = w;
    refMem[addr[11:2]] = w;
  endtask

  task automatic buildProgram();
    placeInstr(0, encodeI(OPC_ADDIU, 0, 10, 'h800));
    placeInstr(1, encodeI(OPC_ADDIU, 0, 1, -5));
    placeInstr(2, encodeI(OPC_ADDIU, 0, 2, 'h1234));
    placeInstr(3, encodeR(1, 2, 3, FUN_ADDU));
    placeInstr(4, encodeI(OPC_SW, 10, 3, 0));
    placeInstr(5, encodeR(1, 2, 4, FUN_AND));
    placeInstr(6, encodeI(OPC_SW, 10, 4, 4));
    placeInstr(7, encodeR(1, 2, 5, FUN_OR));
    placeInstr(8, encodeI(OPC_SW, 10, 5, 8));
    placeInstr(9, encodeI(OPC_ANDI, 1, 6, 'hff00));
    placeInstr(10, encodeI(OPC_SW, 10, 6, 12));
    placeInstr(11, encodeI(OPC_ORI, 2, 7, 'h8001));
    placeInstr(12, encodeI(OPC_SW, 10, 7, 16));
    placeInstr(13, encodeI(OPC_SLTI, 1, 8, -3));
    placeInstr(14, encodeI(OPC_SW, 10, 8, 20));
    placeInstr(15, encodeI(OPC_SLTI, 2, 9, 5));
    placeInstr(16, encodeI(OPC_SW, 10, 9, 24));
    // Word with positive and negative bytes for the loads
    placeInstr(17, encodeI(OPC_ADDIU, 0, 11, 'h807f));
    placeInstr(18, encodeI(OPC_SW, 10, 11, 32));
    placeInstr(19, encodeI(OPC_LW, 10, 12, 32));
    placeInstr(20, encodeI(OPC_SW, 10, 12, 36));
    placeInstr(21, encodeI(OPC_LB, 10, 13, 32));
    placeInstr(22, encodeI(OPC_SW, 10, 13, 40));
    placeInstr(23, encodeI(OPC_LB, 10, 14, 33));
    placeInstr(24, encodeI(OPC_SW, 10, 14, 44));
    placeInstr(25, encodeI(OPC_LB, 10, 15, 34));
    placeInstr(26, encodeI(OPC_SW, 10, 15, 48));
    placeInstr(27, encodeI(OPC_LB, 10, 16, 35));
    placeInstr(28, encodeI(OPC_SW, 10, 16, 52));
    // Not taken, then taken over one store
    placeInstr(29, encodeI(OPC_BGTZ, 1, 0, 1));
    placeInstr(30, encodeI(OPC_SW, 10, 1, 56));
    placeInstr(31, encodeI(OPC_BGTZ, 2, 0, 1));
    placeInstr(32, encodeI(OPC_SW, 10, 0, 60));
    placeInstr(33, encodeJ(35));
    placeInstr(34, encodeI(OPC_SW, 10, 0, 64));
    // Countdown loop with a backward branch
    placeInstr(35, encodeI(OPC_ADDIU, 0, 18, 3));
    placeInstr(36, encodeI(OPC_SW, 10, 18, 68));
    placeInstr(37, encodeI(OPC_ADDIU, 18, 18, -1));
    placeInstr(38, encodeI(OPC_BGTZ, 18, 0, -3));
    placeInstr(39, encodeI(OPC_ADDIU, 0, 17, int'(RESET_PC) + 4 * 44));
    placeInstr(40, encodeR(17, 0, 31, FUN_JALR));
    placeInstr(41, encodeI(OPC_SW, 10, 31, 72));
    placeInstr(42, encodeR(0, 0, 0, FUN_JR));
    placeInstr(43, encodeI(OPC_SW, 10, 0, 76));
    // Subroutine
    placeInstr(44, encodeI(OPC_SW, 10, 2, 80));
    placeInstr(45, encodeR(31, 0, 0, FUN_JR));
  endtask

  // Instruction level model that fills the expected store list
  function automatic int runReference(word_t startPc);
    word_t      regs [32];
    word_t      pc;
    word_t      next;
    word_t      ir;
    word_t      a;
    word_t      b;
    word_t      immS;
    word_t      addr;
    word_t      loaded;
    logic [4:0] rt;
    logic [4:0] rd;
    int         count;
    logic       done;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = startPc;
    count = 0;
    done = 1'b0;
    while (!done && count < 10000) begin
      ir = refMem[pc[11:2]];
      a = regs[ir[25:21]];
      b = regs[ir[20:16]];
      rt = ir[20:16];
      rd = ir[15:11];
      immS = {{16{ir[15]}}, ir[15:0]};
      addr = a + immS;
      next = pc + 32'd4;
      count++;
      case (ir[31:26])
        OPC_SPECIAL: begin
          case (ir[5:0])
            FUN_ADDU: regs[rd] = a + b;
            FUN_AND: regs[rd] = a & b;
            FUN_OR: regs[rd] = a | b;
            FUN_JR: next = a;
            FUN_JALR: begin
              regs[31] = pc + 32'd4;
              next = a;
            end
            default: done = 1'b1;
          endcase
        end
        OPC_J: next = {next[31:28], ir[25:0], 2'b00};
        OPC_BGTZ: begin
          if ($signed(a) > 0) begin
            next = next + {immS[29:0], 2'b00};
          end
        end
        OPC_ADDIU: regs[rt] = addr;
        OPC_SLTI: regs[rt] = ($signed(a) < $signed(immS)) ? 32'd1 : 32'd0;
        OPC_ANDI: regs[rt] = a & {16'h0000, ir[15:0]};
        OPC_ORI: regs[rt] = a | {16'h0000, ir[15:0]};
        OPC_LW: regs[rt] = refMem[addr[11:2]];
        OPC_LB: begin
          loaded = refMem[addr[11:2]] >> {addr[1:0], 3'b000};
          regs[rt] = {{24{loaded[7]}}, loaded[7:0]};
        end
        OPC_SW: begin
          refMem[addr[11:2]] = b;
          expAddr.push_back(addr);
          expData.push_back(b);
        end
        default: done = 1'b1;
      endcase
      regs[0] = '0;
      pc = next;
      if (pc == '0) begin
        done = 1'b1;
      end
    end
    return count;
  endfunction

  task automatic checkWord(string name, word_t got, word_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("** Error: %s got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic checkBit(string name, logic got, logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("** Error: %s got %h, expected %h", name, got, expected);
    end
  endtask

  // Memory model with a random stall about one cycle in four
  always @(negedge clk) begin
    // A stalled access presents the same address again
    if (stalledAccess) begin
      checkWord("memAddr", memAddr, stalledAddr);
    end
    lfsr = nextLfsr(lfsr);
    stallBit = lfsr[0];
    lfsr = nextLfsr(lfsr);
    stall = stallBit & lfsr[0];
    stalledAccess = stall && (memRead || memWrite);
    stalledAddr = memAddr;
    if (memWrite && !stall) begin
      mem[memAddr[11:2]] = memWdata;
      gotAddr.push_back(memAddr);
      gotData.push_back(memWdata);
    end
    memRdata = mem[memAddr[11:2]];
  end

  always @(posedge clk) begin : compareStores
    word_t addr;
    word_t data;
    while (gotAddr.size() > 0) begin
      addr = gotAddr.pop_front();
      data = gotData.pop_front();
      if (storeCount < expAddr.size()) begin
        checkWord("memAddr", addr, expAddr[storeCount]);
        checkWord("memWdata", data, expData[storeCount]);
      end else begin
        errors++;
        $display("Unexpected store to address %h after the expected sequence", addr);
      end
      storeCount++;
    end
  end

  initial begin
    arstN = 1'b0;
    stall = 1'b0;
    memRdata = '0;
    errors = 0;
    checks = 0;
    storeCount = 0;
    stalledAccess = 1'b0;
    stalledAddr = '0;
    lfsr = 32'h599ef0db;
    // Unused words decode as an unknown opcode
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hfc000000 | word_t'(i * 4);
      refMem[i] = mem[i];
    end
    buildProgram();
    instrCount = runReference(RESET_PC);
    cycleLimit = instrCount * 5 * 4;
    repeat (RESET_CYCLES / 2) @(negedge clk);
    checkBit("memWrite", memWrite, 1'b0);
    checkBit("halted", halted, 1'b0);
    repeat (RESET_CYCLES / 2) @(negedge clk);
    checkBit("memRead", memRead, 1'b1);
    checkWord("memAddr", memAddr, RESET_PC);
    arstN = 1'b1;
    cycles = 0;
    while (!halted && cycles < cycleLimit) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("Timeout: core did not halt within %0d cycles", cycleLimit);
    end else begin
      // Core must stay halted with no more stores
      repeat (4) @(negedge clk);
      checkBit("halted", halted, 1'b1);
      checkBit("memWrite", memWrite, 1'b0);
    end
    if (storeCount != expAddr.size()) begin
      errors++;
      $display("Store count mismatch: %0d seen, %0d expected", storeCount, expAddr.size());
    end
    assertFails = i_mipsCore.i_controlFsm.i_mipsCoreProps.failCount;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, assertFails);
    if (errors == 0 && assertFails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mipsCore.f */
source/mipsPkg.sv
source/aluUnit.sv
source/registerFile.sv
source/controlFsm.sv
source/dataPath.sv
source/mipsCore.sv
sim/mipsCore_props.sv
sim/mipsCore_tb.sv

/* Bender.yml */
package:
  name: mipsCore

sources:
  - source/mipsPkg.sv
  - source/aluUnit.sv
  - source/registerFile.sv
  - source/controlFsm.sv
  - source/dataPath.sv
  - source/mipsCore.sv
  - target: simulation
    files:
      - sim/mipsCore_props.sv
      - sim/mipsCore_tb.sv
